/* source/dmem_defs.svh */
`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

// data path width in bits
`define DMEM_DATA_W 64

// byte address width as seen by the memory stage
`define DMEM_ADDR_W 64

// log2 of the number of doublewords held by the RAM
`define DMEM_DEPTH_LOG2 9

`endif

/* source/mem_op_pkg.sv */
`include "dmem_defs.svh"

package mem_op_pkg;

  // memory-stage operations, loads first, then stores
  typedef enum logic [3:0] {
    op_lb  = 4'd0,
    op_lh  = 4'd1,
    op_lw  = 4'd2,
    op_ld  = 4'd3,
    op_lbu = 4'd4,
    op_lhu = 4'd5,
    op_lwu = 4'd6,
    op_sb  = 4'd7,
    op_sh  = 4'd8,
    op_sw  = 4'd9,
    op_sd  = 4'd10
  } mem_op_e;

  // request from the execute stage, one per valid cycle
  typedef struct packed {
    logic                    valid;
    mem_op_e                 op;
    logic [`DMEM_ADDR_W-1:0] addr;
    logic [`DMEM_DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

/* source/mem_bus_pkg.sv */
`include "dmem_defs.svh"

package mem_bus_pkg;

  // port into the byte-writable RAM
  typedef struct packed {
    logic                          en;
    logic                          we;
    logic [`DMEM_DEPTH_LOG2-1:0]   index;
    logic [`DMEM_DATA_W/8-1:0]     wmask;
    logic [`DMEM_DATA_W-1:0]       wdata;
  } ram_req_t;

  // what the load side needs once the read word arrives
  typedef struct packed {
    logic                  valid;
    mem_op_pkg::mem_op_e   op;
    logic [2:0]            offset;
    logic                  misaligned;
  } load_tag_t;

endpackage

/* source/access_decode.sv */
`include "dmem_defs.svh"

module access_decode (
  input  mem_op_pkg::mem_req_t   req,
  output mem_bus_pkg::ram_req_t  ram_req,
  output mem_bus_pkg::load_tag_t tag,
  output logic                   misaligned
);

  logic                          is_load;
  logic                          is_store;
  logic [1:0]                    size;
  logic [2:0]                    offset;
  logic                          bad_align;
  logic                          store_ok;
  logic [`DMEM_DATA_W/8-1:0]     size_mask;

  assign offset = req.addr[2:0];

  // opcode class and access size (0 byte, 1 half, 2 word, 3 double)
  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    size     = 2'd0;
    case (req.op)
      mem_op_pkg::op_lb,
      mem_op_pkg::op_lbu: begin
        is_load = 1'b1;
        size    = 2'd0;
      end
      mem_op_pkg::op_lh,
      mem_op_pkg::op_lhu: begin
        is_load = 1'b1;
        size    = 2'd1;
      end
      mem_op_pkg::op_lw,
      mem_op_pkg::op_lwu: begin
        is_load = 1'b1;
        size    = 2'd2;
      end
      mem_op_pkg::op_ld: begin
        is_load = 1'b1;
        size    = 2'd3;
      end
      mem_op_pkg::op_sb: begin
        is_store = 1'b1;
        size     = 2'd0;
      end
      mem_op_pkg::op_sh: begin
        is_store = 1'b1;
        size     = 2'd1;
      end
      mem_op_pkg::op_sw: begin
        is_store = 1'b1;
        size     = 2'd2;
      end
      mem_op_pkg::op_sd: begin
        is_store = 1'b1;
        size     = 2'd3;
      end
      default: begin
        is_load  = 1'b0;
        is_store = 1'b0;
      end
    endcase
  end

  // natural alignment where bytes never fault
  always_comb begin
    case (size)
      2'd0:    bad_align = 1'b0;
      2'd1:    bad_align = offset[0];
      2'd2:    bad_align = |offset[1:0];
      default: bad_align = |offset;
    endcase
  end

  // lanes covered by the access before shifting to the offset
  always_comb begin
    case (size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign misaligned = req.valid && (is_load || is_store) && bad_align;
  assign store_ok   = req.valid && is_store && !bad_align;

  assign ram_req.en    = req.valid && (is_load || is_store) && !bad_align;
  assign ram_req.we    = store_ok;
  assign ram_req.index = req.addr[`DMEM_DEPTH_LOG2+2:3];
  assign ram_req.wmask = store_ok ? (size_mask << offset) : '0;
  assign ram_req.wdata = req.wdata << {offset, 3'b000};

  assign tag.valid      = req.valid && is_load;
  assign tag.op         = req.op;
  assign tag.offset     = offset;
  assign tag.misaligned = bad_align;

  // a write must start on a multiple of its own lane count
  always_comb begin
    if (ram_req.we) begin
      assert ((offset & 3'($countones(ram_req.wmask) - 1)) == 3'd0)
        else $error("misaligned request reached the RAM write port");
    end
  end

endmodule

/* source/byte_ram.sv */
`include "dmem_defs.svh"

module byte_ram #(
  parameter int DEPTH_LOG2 = `DMEM_DEPTH_LOG2
) (
  input  logic                    clk,
  input  mem_bus_pkg::ram_req_t   ram_req,
  output logic [`DMEM_DATA_W-1:0] rword
);

  localparam int DEPTH = 1 << DEPTH_LOG2;
  localparam int LANES = `DMEM_DATA_W / 8;

  logic [`DMEM_DATA_W-1:0] mem [DEPTH];
  logic [DEPTH_LOG2-1:0]   index;

  assign index = ram_req.index[DEPTH_LOG2-1:0];

  // per-lane write, untouched lanes keep their old bytes
  always_ff @(posedge clk) begin
    if (ram_req.en && ram_req.we) begin
      for (int i = 0; i < LANES; i++) begin
        if (ram_req.wmask[i]) begin
          mem[index][i*8 +: 8] <= ram_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // registered read, sees the contents from before this edge
  always_ff @(posedge clk) begin
    if (ram_req.en) begin
      rword <= mem[index];
    end
  end

  // lanes may only be enabled on a write
  assert property (@(posedge clk) (ram_req.wmask != '0) |-> ram_req.we)
    else $error("byte_ram: wmask set without write enable");

endmodule

/* source/load_align.sv */
`include "dmem_defs.svh"

module load_align (
  input  logic                    clk,
  input  logic                    reset,
  input  mem_bus_pkg::load_tag_t  tag,
  input  logic [`DMEM_DATA_W-1:0] rword,
  output logic                    rvalid,
  output logic [`DMEM_DATA_W-1:0] rdata
);

  mem_bus_pkg::load_tag_t  tag_q;
  logic [`DMEM_DATA_W-1:0] shifted;

  // tag lines up with the registered read word
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_q.valid <= 1'b0;
    end else begin
      tag_q <= tag;
    end
  end

  // addressed lanes down to bit 0
  assign shifted = rword >> {tag_q.offset, 3'b000};

  always_comb begin
    if (tag_q.misaligned) begin
      rdata = '0;
    end else begin
      case (tag_q.op)
        mem_op_pkg::op_lb:  rdata = {{56{shifted[7]}}, shifted[7:0]};
        mem_op_pkg::op_lh:  rdata = {{48{shifted[15]}}, shifted[15:0]};
        mem_op_pkg::op_lw:  rdata = {{32{shifted[31]}}, shifted[31:0]};
        mem_op_pkg::op_lbu: rdata = {56'd0, shifted[7:0]};
        mem_op_pkg::op_lhu: rdata = {48'd0, shifted[15:0]};
        mem_op_pkg::op_lwu: rdata = {32'd0, shifted[31:0]};
        mem_op_pkg::op_ld:  rdata = shifted;
        // stores never raise valid
        default:            rdata = '0;
      endcase
    end
  end

  assign rvalid = tag_q.valid;

  // each result belongs to a load opcode
  assert property (@(posedge clk) disable iff (reset)
                   rvalid |-> tag_q.op inside {mem_op_pkg::op_lb, mem_op_pkg::op_lh,
                                               mem_op_pkg::op_lw, mem_op_pkg::op_ld,
                                               mem_op_pkg::op_lbu, mem_op_pkg::op_lhu,
                                               mem_op_pkg::op_lwu})
    else $error("load_align: rvalid for a non-load opcode");

endmodule

/* source/data_mem.sv */
`include "dmem_defs.svh"

module data_mem (
  input  logic                    clk,
  input  logic                    reset,
  input  mem_op_pkg::mem_req_t    req,
  output logic                    rvalid,
  output logic [`DMEM_DATA_W-1:0] rdata,
  output logic                    misaligned
);

  mem_bus_pkg::ram_req_t   ram_req;
  mem_bus_pkg::load_tag_t  tag;
  logic [`DMEM_DATA_W-1:0] rword;

  // request side, purely combinational
  access_decode u_decode (
    .req        (req),
    .ram_req    (ram_req),
    .tag        (tag),
    .misaligned (misaligned)
  );

  byte_ram #(
    .DEPTH_LOG2 (`DMEM_DEPTH_LOG2)
  ) u_ram (
    .clk     (clk),
    .ram_req (ram_req),
    .rword   (rword)
  );

  // result side, one cycle behind the request
  load_align u_align (
    .clk    (clk),
    .reset  (reset),
    .tag    (tag),
    .rword  (rword),
    .rvalid (rvalid),
    .rdata  (rdata)
  );

endmodule

/* verification/data_mem_tb.sv */
`include "dmem_defs.svh"

module data_mem_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int WORDS        = 1 << `DMEM_DEPTH_LOG2;
  localparam int BYTES        = WORDS * 8;
  localparam int N_RANDOM     = 600;
  // fill pass plus directed sections and random traffic with headroom
  localparam int MAX_TXNS     = WORDS + 300 + N_RANDOM;

  logic                    clk;
  logic                    reset;
  mem_op_pkg::mem_req_t    req;
  logic                    rvalid;
  logic [`DMEM_DATA_W-1:0] rdata;
  logic                    misaligned;

  // expected response of the request currently on req
  logic                    exp_misaligned;
  logic                    exp_load;
  logic [`DMEM_DATA_W-1:0] exp_data;
  // the same one cycle later when the result shows up
  logic                    exp_load_q;
  logic [`DMEM_DATA_W-1:0] exp_data_q;

  logic [7:0]  ref_mem [BYTES];
  logic [31:0] rng;

  int reset_errs = 0;
  int mis_errs   = 0;
  int valid_errs = 0;
  int data_errs  = 0;

  data_mem u_dut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .misaligned (misaligned)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      exp_load_q <= 1'b0;
      exp_data_q <= '0;
    end else begin
      exp_load_q <= exp_load;
      exp_data_q <= exp_data;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int access_bytes(input mem_op_pkg::mem_op_e op);
    case (op)
      mem_op_pkg::op_lb, mem_op_pkg::op_lbu, mem_op_pkg::op_sb: return 1;
      mem_op_pkg::op_lh, mem_op_pkg::op_lhu, mem_op_pkg::op_sh: return 2;
      mem_op_pkg::op_lw, mem_op_pkg::op_lwu, mem_op_pkg::op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic bit is_store_op(input mem_op_pkg::mem_op_e op);
    return op inside {mem_op_pkg::op_sb, mem_op_pkg::op_sh, mem_op_pkg::op_sw,
                      mem_op_pkg::op_sd};
  endfunction

  function automatic bit is_signed_op(input mem_op_pkg::mem_op_e op);
    return op inside {mem_op_pkg::op_lb, mem_op_pkg::op_lh, mem_op_pkg::op_lw};
  endfunction

  // little-endian gather from the byte model followed by extension
  function automatic logic [63:0] model_load(input mem_op_pkg::mem_op_e op,
                                             input int base);
    int          n;
    logic [63:0] value;
    n     = access_bytes(op);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[i*8 +: 8] = ref_mem[base + i];
    end
    if (is_signed_op(op) && value[n*8-1]) begin
      for (int i = n * 8; i < 64; i++) begin
        value[i] = 1'b1;
      end
    end
    return value;
  endfunction

  // whole-address dependent pattern for the initial contents
  function automatic logic [63:0] fill_word(input logic [63:0] addr);
    return {~addr[31:0] ^ 32'h3c5a_96e1, addr[31:0] ^ 32'h6c8e_9cf5};
  endfunction

  // valid aligned loads alternate with invalid misaligned-looking requests
  task automatic drive_during_reset();
    for (int k = 0; k < RESET_CYCLES - 1; k++) begin
      @(posedge clk);
      req.valid <= (k % 2 == 0);
      req.op    <= (k % 2 == 0) ? mem_op_pkg::op_ld : mem_op_pkg::op_sd;
      req.addr  <= (k % 2 == 0) ? 64'd8 : 64'd5;
      req.wdata <= '1;
    end
    @(posedge clk);
    req.valid <= 1'b0;
    reset     <= 1'b0;
  endtask

  task automatic issue(input mem_op_pkg::mem_op_e op, input logic [63:0] addr,
                       input logic [63:0] wdata);
    int   n;
    int   base;
    logic bad;
    n    = access_bytes(op);
    base = int'(addr[`DMEM_DEPTH_LOG2+2:0]);
    bad  = (base % n) != 0;
    @(posedge clk);
    req.valid      <= 1'b1;
    req.op         <= op;
    req.addr       <= addr;
    req.wdata      <= wdata;
    exp_misaligned <= bad;
    exp_load       <= !is_store_op(op);
    exp_data       <= (bad || is_store_op(op)) ? 64'd0 : model_load(op, base);
    // model store lands before any later request is modelled
    if (is_store_op(op) && !bad) begin
      for (int i = 0; i < n; i++) begin
        ref_mem[base + i] = wdata[i*8 +: 8];
      end
    end
  endtask

  task automatic idle();
    @(posedge clk);
    req.valid      <= 1'b0;
    exp_misaligned <= 1'b0;
    exp_load       <= 1'b0;
    exp_data       <= '0;
  endtask

  task automatic fill_memory();
    logic [63:0] a;
    for (int i = 0; i < WORDS; i++) begin
      a = 64'(i) << 3;
      issue(mem_op_pkg::op_sd, a, fill_word(a));
    end
  endtask

  task automatic round_trip();
    issue(mem_op_pkg::op_sd, 64'd0, 64'h0123_4567_89ab_cdef);
    issue(mem_op_pkg::op_ld, 64'd0, 64'd0);
    issue(mem_op_pkg::op_sd, 64'(37 * 8), 64'hfedc_ba98_7654_3210);
    idle();
    issue(mem_op_pkg::op_ld, 64'(37 * 8), 64'd0);
    issue(mem_op_pkg::op_sd, 64'((WORDS - 1) * 8), 64'h8000_0000_0000_0001);
    issue(mem_op_pkg::op_ld, 64'((WORDS - 1) * 8), 64'd0);
    issue(mem_op_pkg::op_ld, 64'd0, 64'd0);
  endtask

  // upper wdata bits are junk and must not leak into other lanes
  task automatic sub_word_merge();
    issue(mem_op_pkg::op_sd, 64'(100 * 8), 64'h1122_3344_5566_7788);
    issue(mem_op_pkg::op_sb, 64'(100 * 8 + 3), 64'hdead_beef_cafe_00a5);
    issue(mem_op_pkg::op_ld, 64'(100 * 8), 64'd0);
    issue(mem_op_pkg::op_sh, 64'(100 * 8 + 6), 64'h1111_2222_3333_b00c);
    issue(mem_op_pkg::op_ld, 64'(100 * 8), 64'd0);
    issue(mem_op_pkg::op_sw, 64'(100 * 8), 64'h5555_6666_9abc_def0);
    issue(mem_op_pkg::op_ld, 64'(100 * 8), 64'd0);
    issue(mem_op_pkg::op_sw, 64'(100 * 8 + 4), 64'hffff_ffff_0bad_f00d);
    issue(mem_op_pkg::op_ld, 64'(100 * 8), 64'd0);
  endtask

  task automatic load_extension();
    logic [63:0]         pattern;
    mem_op_pkg::mem_op_e op;
    for (int p = 0; p < 2; p++) begin
      pattern = (p == 0) ? 64'h8f7e_80ff_017f_fe80 : ~64'h8f7e_80ff_017f_fe80;
      issue(mem_op_pkg::op_sd, 64'(150 * 8), pattern);
      // load opcodes are the first seven codes
      for (int k = 0; k < 7; k++) begin
        op = mem_op_pkg::mem_op_e'(4'(k));
        for (int off = 0; off < 8; off++) begin
          if (off % access_bytes(op) == 0) begin
            issue(op, 64'(150 * 8 + off), 64'd0);
          end
        end
      end
    end
  endtask

  task automatic misaligned_access();
    issue(mem_op_pkg::op_sd, 64'(200 * 8), 64'hc001_d00d_0ff1_ce55);
    issue(mem_op_pkg::op_sh, 64'(200 * 8 + 1), 64'hffff_ffff_ffff_ffff);
    issue(mem_op_pkg::op_sw, 64'(200 * 8 + 2), 64'hffff_ffff_ffff_ffff);
    issue(mem_op_pkg::op_sd, 64'(200 * 8 + 4), 64'hffff_ffff_ffff_ffff);
    issue(mem_op_pkg::op_sw, 64'(200 * 8 + 6), 64'hffff_ffff_ffff_ffff);
    issue(mem_op_pkg::op_ld, 64'(200 * 8), 64'd0);
    issue(mem_op_pkg::op_lh, 64'(200 * 8 + 3), 64'd0);
    issue(mem_op_pkg::op_lw, 64'(200 * 8 + 1), 64'd0);
    issue(mem_op_pkg::op_ld, 64'(200 * 8 + 5), 64'd0);
    issue(mem_op_pkg::op_lhu, 64'(200 * 8 + 7), 64'd0);
    issue(mem_op_pkg::op_lwu, 64'(200 * 8 + 2), 64'd0);
    issue(mem_op_pkg::op_lb, 64'(200 * 8 + 7), 64'd0);
  endtask

  task automatic random_traffic();
    mem_op_pkg::mem_op_e op;
    logic [63:0]         addr;
    logic [63:0]         data;
    for (int t = 0; t < N_RANDOM; t++) begin
      rng  = lcg_step(rng);
      op   = mem_op_pkg::mem_op_e'(4'(rng[31:16] % 16'd11));
      rng  = lcg_step(rng);
      addr = 64'(rng[31 -: `DMEM_DEPTH_LOG2 + 3]);
      rng  = lcg_step(rng);
      // mostly aligned so the RAM path sees plenty of traffic
      if (rng[31:30] != 2'b00) begin
        addr[2:0] = addr[2:0] & ~3'(access_bytes(op) - 1);
      end
      data[63:32] = rng;
      rng         = lcg_step(rng);
      data[31:0]  = rng;
      issue(op, addr, data);
    end
  endtask

  assert property (@(posedge clk) reset |-> !misaligned)
    else begin
      reset_errs++;
      $display("ERROR at time %0t: misaligned high during reset", $time);
    end

  assert property (@(posedge clk) $past(reset) |-> !rvalid)
    else begin
      reset_errs++;
      $display("ERROR at time %0t: rvalid high after a reset edge", $time);
    end

  assert property (@(posedge clk) disable iff (reset) misaligned == exp_misaligned)
    else begin
      mis_errs++;
      $display("ERROR at time %0t: misaligned is %0b, expected %0b", $time,
               $sampled(misaligned), $sampled(exp_misaligned));
    end

  assert property (@(posedge clk) disable iff (reset) rvalid == exp_load_q)
    else begin
      valid_errs++;
      $display("ERROR at time %0t: rvalid is %0b, expected %0b", $time,
               $sampled(rvalid), $sampled(exp_load_q));
    end

  assert property (@(posedge clk) disable iff (reset) rvalid |-> rdata == exp_data_q)
    else begin
      data_errs++;
      $display("ERROR at time %0t: rdata is %h, expected %h", $time,
               $sampled(rdata), $sampled(exp_data_q));
    end

  initial begin
    req            = '0;
    exp_misaligned = 1'b0;
    exp_load       = 1'b0;
    exp_data       = '0;
    rng            = 32'haca35093;
    reset          = 1'b1;
    drive_during_reset();
    idle();
    fill_memory();
    round_trip();
    sub_word_merge();
    load_extension();
    misaligned_access();
    random_traffic();
    repeat (3) idle();
    @(posedge clk);
    $display("errors: reset %0d, misaligned %0d, rvalid %0d, rdata %0d",
             reset_errs, mis_errs, valid_errs, data_errs);
    if (reset_errs + mis_errs + valid_errs + data_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((RESET_CYCLES + MAX_TXNS + 100) * CLK_PERIOD);
    $display("timeout: the run did not finish in the expected time");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+source
source/mem_op_pkg.sv
source/mem_bus_pkg.sv
source/access_decode.sv
source/byte_ram.sv
source/load_align.sv
source/data_mem.sv
verification/data_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= data_mem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
